// ==== include/axis_fifo_macros.svh ====
// fixed build constants; depth is a power of two set by the address width, user marker is masked
`ifndef AXIS_FIFO_MACROS_SVH
`define AXIS_FIFO_MACROS_SVH

// payload width of one beat
`define AXIS_DATA_W 16

// user sideband width
`define AXIS_USER_W 1

// memory address width, 16 beats deep
`define FIFO_ADDR_W 4

// bad-frame marker carried in user on the last beat
`define USER_BAD_VALUE 1

// only masked user bits take part in the bad-frame test
`define USER_BAD_MASK 1

`endif

// ==== src/axis_fifo_pkg.sv ====
// shared types for the frame FIFO; widths come from the macros header and are fixed at build
`include "axis_fifo_macros.svh"

package axis_fifo_pkg;

    // payload and sideband vectors
    typedef logic [`AXIS_DATA_W-1:0] data_t;
    typedef logic [`AXIS_USER_W-1:0] user_t;

    // memory index
    typedef logic [`FIFO_ADDR_W-1:0] addr_t;

    // pointer with one extra wrap bit to tell full from empty
    typedef logic [`FIFO_ADDR_W:0] ptr_t;

    // occupancy, 0 up to the full depth
    typedef logic [`FIFO_ADDR_W:0] depth_t;

    // one stream beat, as stored in memory and carried on both ports
    typedef struct packed {
        data_t data;
        logic  last;
        user_t user;
    } axis_beat_t;

    // writer state
    typedef enum logic {
        WR_STORE,
        WR_DROP
    } wr_state_t;

endpackage

// ==== src/frame_write_ctrl.sv ====
// input side of the frame FIFO; a frame is only committed on its last beat, oversize frames are dropped
`timescale 1ns/1ps
`include "axis_fifo_macros.svh"

module frame_write_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  axis_fifo_pkg::axis_beat_t s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,
    input  logic                     full,
    input  logic                     frame_ovf,
    output logic                     wr_en,
    output axis_fifo_pkg::addr_t     wr_addr,
    output axis_fifo_pkg::axis_beat_t wr_beat,
    output axis_fifo_pkg::ptr_t      wr_ptr,
    output axis_fifo_pkg::ptr_t      commit_ptr,
    output logic                     status_overflow,
    output logic                     status_bad_frame,
    output logic                     status_good_frame
);

    import axis_fifo_pkg::*;

    wr_state_t state;
    logic      accept;
    logic      drop_beat;
    logic      is_bad;

    // an oversize frame keeps ready high so its tail can be discarded
    assign s_ready = !full || frame_ovf;

    assign accept = s_valid && s_ready;

    // once a frame fills the whole memory on its own, the rest of it is thrown away
    assign drop_beat = (state == WR_DROP) || frame_ovf;

    assign is_bad = (s_beat.user & user_t'(`USER_BAD_MASK)) ==
                    (user_t'(`USER_BAD_VALUE) & user_t'(`USER_BAD_MASK));

    assign wr_en   = accept && !drop_beat;
    assign wr_addr = addr_t'(wr_ptr);
    assign wr_beat = s_beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= WR_STORE;
            wr_ptr            <= '0;
            commit_ptr        <= '0;
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;
        end else begin
            // status outputs are single-cycle pulses
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;

            if (accept) begin
                if (drop_beat) begin
                    if (s_beat.last) begin
                        // forget everything written for this frame
                        wr_ptr          <= commit_ptr;
                        state           <= WR_STORE;
                        status_overflow <= 1'b1;
                    end else begin
                        state <= WR_DROP;
                    end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (s_beat.last) begin
                        if (is_bad) begin
                            wr_ptr           <= commit_ptr;
                            status_bad_frame <= 1'b1;
                        end else begin
                            // frame becomes visible to the read side
                            commit_ptr        <= wr_ptr + 1'b1;
                            status_good_frame <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // frame_ovf comes from the occupancy monitor; the open frame never outgrows the memory
    wr_open_frame_bound: assert property (
        @(posedge clk) disable iff (rst)
            ptr_t'(wr_ptr - commit_ptr) <= ptr_t'(2 ** `FIFO_ADDR_W)
    ) else $error("open frame grew beyond the memory size");

endmodule

// ==== src/frame_ram.sv ====
// 16-beat simple dual-port memory; read data appears one cycle after rd_en and holds otherwise
`timescale 1ns/1ps

module frame_ram (
    input  logic                      clk,
    input  logic                      wr_en,
    input  axis_fifo_pkg::addr_t      wr_addr,
    input  axis_fifo_pkg::axis_beat_t wr_beat,
    input  logic                      rd_en,
    input  axis_fifo_pkg::addr_t      rd_addr,
    output axis_fifo_pkg::axis_beat_t rd_beat
);

    import axis_fifo_pkg::*;

    axis_beat_t mem [2**$bits(addr_t)];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // registered read port, output kept while no read is issued
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

endmodule

// ==== src/occupancy_monitor.sv ====
// pointer comparisons for the frame FIFO; depth figures lag the pointers by one cycle
`timescale 1ns/1ps
`include "axis_fifo_macros.svh"

module occupancy_monitor (
    input  logic                  clk,
    input  logic                  rst,
    input  axis_fifo_pkg::ptr_t   wr_ptr,
    input  axis_fifo_pkg::ptr_t   commit_ptr,
    input  axis_fifo_pkg::ptr_t   rd_ptr,
    output logic                  full,
    output logic                  frame_ovf,
    output logic                  empty,
    output axis_fifo_pkg::depth_t status_depth,
    output axis_fifo_pkg::depth_t status_depth_commit
);

    import axis_fifo_pkg::*;

    // only the wrap bit set
    localparam ptr_t WRAP = ptr_t'(1) << `FIFO_ADDR_W;

    // full when the wrap bits differ and the index bits agree
    assign full = wr_ptr == (rd_ptr ^ WRAP);

    // the open frame alone occupies every slot
    assign frame_ovf = wr_ptr == (commit_ptr ^ WRAP);

    // nothing committed is left to read
    assign empty = commit_ptr == rd_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            status_depth        <= '0;
            status_depth_commit <= '0;
        end else begin
            status_depth        <= wr_ptr - rd_ptr;
            status_depth_commit <= commit_ptr - rd_ptr;
        end
    end

    // commit and read pointers live in different modules; they must never drift apart
    depth_commit_bound: assert property (
        @(posedge clk) disable iff (rst) status_depth_commit <= WRAP
    ) else $error("committed depth beyond memory size");

endmodule

// ==== src/read_pipeline.sv ====
// output side of the frame FIFO; one RAM read stage plus one output register, no bubble under ready
`timescale 1ns/1ps

module read_pipeline (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      empty,
    output logic                      rd_en,
    output axis_fifo_pkg::addr_t      rd_addr,
    output axis_fifo_pkg::ptr_t       rd_ptr,
    input  axis_fifo_pkg::axis_beat_t rd_beat,
    output axis_fifo_pkg::axis_beat_t m_beat,
    output logic                      m_valid,
    input  logic                      m_ready
);

    import axis_fifo_pkg::*;

    // beat sitting in the RAM output register
    logic rd_valid;
    logic out_free;
    logic stage_free;

    // output register empty or being taken this cycle
    assign out_free = !m_valid || m_ready;

    // RAM stage can take a new read if it is empty or drains into the output
    assign stage_free = !rd_valid || out_free;

    assign rd_en   = !empty && stage_free;
    assign rd_addr = addr_t'(rd_ptr);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
            m_valid  <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // valid follows the one-cycle RAM latency
            if (stage_free) begin
                rd_valid <= rd_en;
            end
            if (out_free) begin
                m_valid <= rd_valid;
            end
        end
    end

    // output beat, held while the sink stalls
    always_ff @(posedge clk) begin
        if (out_free && rd_valid) begin
            m_beat <= rd_beat;
        end
    end

    // a stalled beat in the RAM stage must survive until the output register takes it
    rd_beat_held: assert property (
        @(posedge clk) disable iff (rst) (rd_valid && !out_free) |=> $stable(rd_beat)
    ) else $error("RAM read data changed while its beat was waiting");

endmodule

// ==== src/axis_frame_fifo.sv ====
// 16-beat frame FIFO with oversize and bad-frame drop; a frame is readable only after its last beat
`timescale 1ns/1ps

module axis_frame_fifo (
    input  logic                      clk,
    input  logic                      rst,

    // input stream
    input  axis_fifo_pkg::axis_beat_t s_beat,
    input  logic                      s_valid,
    output logic                      s_ready,

    // output stream
    output axis_fifo_pkg::axis_beat_t m_beat,
    output logic                      m_valid,
    input  logic                      m_ready,

    // status
    output axis_fifo_pkg::depth_t     status_depth,
    output axis_fifo_pkg::depth_t     status_depth_commit,
    output logic                      status_overflow,
    output logic                      status_bad_frame,
    output logic                      status_good_frame
);

    import axis_fifo_pkg::*;

    logic       wr_en;
    addr_t      wr_addr;
    axis_beat_t wr_beat;
    ptr_t       wr_ptr;
    ptr_t       commit_ptr;

    logic       rd_en;
    addr_t      rd_addr;
    ptr_t       rd_ptr;
    axis_beat_t rd_beat;

    logic       full;
    logic       frame_ovf;
    logic       empty;

    frame_write_ctrl u_write_ctrl (
        .clk               (clk),
        .rst               (rst),
        .s_beat            (s_beat),
        .s_valid           (s_valid),
        .s_ready           (s_ready),
        .full              (full),
        .frame_ovf         (frame_ovf),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_beat           (wr_beat),
        .wr_ptr            (wr_ptr),
        .commit_ptr        (commit_ptr),
        .status_overflow   (status_overflow),
        .status_bad_frame  (status_bad_frame),
        .status_good_frame (status_good_frame)
    );

    frame_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (wr_beat),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_beat (rd_beat)
    );

    occupancy_monitor u_occupancy (
        .clk                 (clk),
        .rst                 (rst),
        .wr_ptr              (wr_ptr),
        .commit_ptr          (commit_ptr),
        .rd_ptr              (rd_ptr),
        .full                (full),
        .frame_ovf           (frame_ovf),
        .empty               (empty),
        .status_depth        (status_depth),
        .status_depth_commit (status_depth_commit)
    );

    read_pipeline u_read (
        .clk     (clk),
        .rst     (rst),
        .empty   (empty),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_ptr  (rd_ptr),
        .rd_beat (rd_beat),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

// ==== tb/tb_axis_frame_fifo.sv ====
// frame FIFO testbench; stops at the first mismatch, sink ready is random with a fixed seed
`timescale 1ns/1ps

module tb_axis_frame_fifo;

    import axis_fifo_pkg::*;

    typedef enum int {SINK_READY, SINK_RANDOM, SINK_HOLD} sink_mode_t;
    typedef enum int {OUT_GOOD, OUT_BAD, OUT_OVF} outcome_t;

    logic       clk;
    logic       rst;
    axis_beat_t s_beat;
    logic       s_valid;
    logic       s_ready;
    axis_beat_t m_beat;
    logic       m_valid;
    logic       m_ready;
    depth_t     status_depth;
    depth_t     status_depth_commit;
    logic       status_overflow;
    logic       status_bad_frame;
    logic       status_good_frame;

    // stimulus table, one entry per frame
    string      row_name[$];
    int         row_len[$];
    bit         row_bad[$];
    sink_mode_t row_mode[$];
    int         row_hold[$];
    outcome_t   row_outcome[$];
    bit         row_stall[$];
    bit         row_depth[$];

    // scoreboard of beats still to come out, with the test each belongs to
    axis_beat_t expect_q[$];
    string      expect_name[$];

    sink_mode_t sink_mode;
    int         hold_left;
    int         timeout_cycles = 0;
    int         good_seen = 0;
    int         bad_seen = 0;
    int         ovf_seen = 0;
    int         good_exp = 0;
    int         bad_exp = 0;
    int         ovf_exp = 0;

    axis_frame_fifo DUT (
        .clk                 (clk),
        .rst                 (rst),
        .s_beat              (s_beat),
        .s_valid             (s_valid),
        .s_ready             (s_ready),
        .m_beat              (m_beat),
        .m_valid             (m_valid),
        .m_ready             (m_ready),
        .status_depth        (status_depth),
        .status_depth_commit (status_depth_commit),
        .status_overflow     (status_overflow),
        .status_bad_frame    (status_bad_frame),
        .status_good_frame   (status_good_frame)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input string what, input int exp, input int act);
        assert (exp == act) else
            stop_on_error($sformatf("[FAIL] %s %s expected %0d actual %0d", name, what, exp, act));
    endtask

    task automatic add_row(input string name, input int len, input bit bad, input sink_mode_t mode,
                           input int hold, input outcome_t outcome, input bit stall,
                           input bit depth);
        row_name.push_back(name);
        row_len.push_back(len);
        row_bad.push_back(bad);
        row_mode.push_back(mode);
        row_hold.push_back(hold);
        row_outcome.push_back(outcome);
        row_stall.push_back(stall);
        row_depth.push_back(depth);
    endtask

    // data counts up from a per-row base, user 1 on the last beat marks a bad frame
    function automatic axis_beat_t make_beat(input int r, input int idx);
        axis_beat_t beat;
        beat.data = data_t'((r + 1) * 256 + idx);
        beat.last = (idx == row_len[r] - 1);
        beat.user = (row_bad[r] && beat.last) ? user_t'(1) : user_t'(0);
        return beat;
    endfunction

    // sink compares at the falling edge, ready changes just after the rising edge
    always begin
        @(negedge clk);
        if (!rst && m_valid && m_ready) begin
            assert (expect_q.size() > 0) else
                stop_on_error("an output beat arrived while no frame was expected");
            assert (m_beat == expect_q[0]) else
                stop_on_error($sformatf("[FAIL] %s beat expected %h actual %h",
                                        expect_name[0], expect_q[0], m_beat));
            void'(expect_q.pop_front());
            void'(expect_name.pop_front());
        end
        @(posedge clk);
        #1;
        if (hold_left > 0) begin
            m_ready = 1'b0;
            hold_left--;
        end else if (sink_mode == SINK_READY) begin
            m_ready = 1'b1;
        end else begin
            m_ready = ($urandom & 1) != 0;
        end
    end

    // status pulses are one cycle wide, so one falling edge sees each
    always @(negedge clk) begin
        if (!rst) begin
            if (status_good_frame) good_seen++;
            if (status_bad_frame) bad_seen++;
            if (status_overflow) ovf_seen++;
        end
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        stop_on_error("timeout: the tests did not finish within the expected number of cycles");
    end

    task automatic send_frame(input int r, output bit stalled);
        bit taken;
        stalled = 1'b0;
        for (int i = 0; i < row_len[r]; i++) begin
            s_beat  = make_beat(r, i);
            s_valid = 1'b1;
            taken   = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = s_ready;
                if (!taken) stalled = 1'b1;
                // an oversize frame into an empty FIFO is never back-pressured
                if (row_outcome[r] == OUT_OVF) begin
                    check_value(row_name[r], "s_ready", 1, int'(s_ready));
                end
                @(posedge clk);
                #1;
            end
        end
        s_valid = 1'b0;
        s_beat  = '0;
    endtask

    task automatic drain_fifo(input string name);
        while (expect_q.size() != 0 || m_valid) begin
            @(posedge clk);
            #1;
        end
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        check_value(name, "status_depth after drain", 0, int'(status_depth));
        check_value(name, "status_depth_commit after drain", 0, int'(status_depth_commit));
    endtask

    task automatic check_commit_depth(input int r);
        bit seen;
        int last_val;
        seen = 1'b0;
        last_val = 0;
        repeat (4) begin
            @(negedge clk);
            last_val = int'(status_depth_commit);
            if (last_val == row_len[r]) seen = 1'b1;
        end
        @(posedge clk);
        #1;
        assert (seen) else
            stop_on_error($sformatf("[FAIL] %s commit depth expected %0d actual %0d",
                                    row_name[r], row_len[r], last_val));
    endtask

    task automatic run_row(input int r);
        bit stalled;
        // holds and oversize frames need an empty FIFO to mean anything
        if (row_hold[r] > 0 || row_outcome[r] == OUT_OVF) drain_fifo(row_name[r]);
        @(negedge clk);
        sink_mode = row_mode[r];
        if (row_hold[r] > 0) hold_left = row_hold[r];
        @(posedge clk);
        #1;
        if (row_outcome[r] == OUT_GOOD) begin
            for (int i = 0; i < row_len[r]; i++) begin
                expect_q.push_back(make_beat(r, i));
                expect_name.push_back(row_name[r]);
            end
        end
        send_frame(r, stalled);
        if (row_depth[r]) begin
            check_commit_depth(r);
        end else begin
            @(posedge clk);
            #1;
        end
        case (row_outcome[r])
            OUT_GOOD: good_exp++;
            OUT_BAD:  bad_exp++;
            default:  ovf_exp++;
        endcase
        check_value(row_name[r], "good_frame pulses", good_exp, good_seen);
        check_value(row_name[r], "bad_frame pulses", bad_exp, bad_seen);
        check_value(row_name[r], "overflow pulses", ovf_exp, ovf_seen);
        if (row_stall[r]) check_value(row_name[r], "s_ready went low", 1, int'(stalled));
    endtask

    initial begin
        int total_beats;
        clk       = 1'b0;
        rst       = 1'b1;
        s_beat    = '0;
        s_valid   = 1'b0;
        m_ready   = 1'b0;
        sink_mode = SINK_READY;
        hold_left = 0;
        void'($urandom(89873));

        //      name          len bad mode         hold outcome  stall depth
        add_row("good_1",      1, 0, SINK_READY,   0,  OUT_GOOD, 0, 0);
        add_row("good_5",      5, 0, SINK_READY,   0,  OUT_GOOD, 0, 0);
        add_row("good_16",    16, 0, SINK_READY,   0,  OUT_GOOD, 0, 0);
        add_row("bad_6",       6, 1, SINK_READY,   0,  OUT_BAD,  0, 0);
        add_row("after_bad",   4, 0, SINK_READY,   0,  OUT_GOOD, 0, 0);
        add_row("oversize_20",20, 0, SINK_READY,   0,  OUT_OVF,  0, 0);
        add_row("after_ovf",   3, 0, SINK_RANDOM,  0,  OUT_GOOD, 0, 0);
        // 16 memory slots plus two read stages, so the third frame stalls
        add_row("hold_a",      7, 0, SINK_HOLD,   60,  OUT_GOOD, 0, 0);
        add_row("hold_b",      7, 0, SINK_RANDOM,  0,  OUT_GOOD, 0, 0);
        add_row("hold_c",      7, 0, SINK_RANDOM,  0,  OUT_GOOD, 1, 0);
        add_row("depth_5",     5, 0, SINK_HOLD,   30,  OUT_GOOD, 0, 1);
        add_row("random_8",    8, 0, SINK_RANDOM,  0,  OUT_GOOD, 0, 0);

        total_beats = 0;
        foreach (row_len[r]) total_beats += row_len[r];
        timeout_cycles = total_beats * 40;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        check_value("reset", "m_valid", 0, int'(m_valid));
        check_value("reset", "s_ready", 1, int'(s_ready));
        check_value("reset", "status_overflow", 0, int'(status_overflow));
        check_value("reset", "status_bad_frame", 0, int'(status_bad_frame));
        check_value("reset", "status_good_frame", 0, int'(status_good_frame));
        check_value("reset", "status_depth", 0, int'(status_depth));
        check_value("reset", "status_depth_commit", 0, int'(status_depth_commit));

        foreach (row_name[r]) run_row(r);
        drain_fifo("final_drain");

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
src/axis_fifo_pkg.sv
src/frame_write_ctrl.sv
src/frame_ram.sv
src/occupancy_monitor.sv
src/read_pipeline.sv
src/axis_frame_fifo.sv
tb/tb_axis_frame_fifo.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the frame FIFO testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f sim.f --top-module tb_axis_frame_fifo -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx ">>> PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
